// ==== verilog/mem_cfg_pkg.sv ====
// geometry and latency constants of the memory column
// cache sets and blocks, backing memory depth and timing

package mem_cfg_pkg;

  localparam int data_width = 32;
  localparam int addr_width = 10;

  // cache geometry
  localparam int block_words = 4;
  localparam int num_sets = 8;
  localparam int offset_width = $clog2(block_words);
  localparam int index_width = $clog2(num_sets);
  localparam int tag_width = addr_width - index_width - offset_width;
  localparam int block_width = data_width * block_words;

  // backing memory
  localparam int block_addr_width = addr_width - offset_width;
  localparam int mem_blocks = 2 ** block_addr_width;
  localparam int mem_latency = 4;

  // word at address a powers up as a ^ mem_init_key
  localparam logic [31:0] mem_init_key = 32'h5a3c_96e1;

endpackage

// ==== verilog/mem_link_pkg.sv ====
// host link opcodes and request payload layout
// payload word is store data or a stat command

package mem_link_pkg;

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_stat  = 2'd2
  } op_e;

  // sel 0 reads the hit counter, 1 the miss counter
  typedef struct packed {
    logic [15:0] tag;
    logic        sel;
    logic [14:0] unused;
  } stat_cmd_t;

  typedef union packed {
    logic [mem_cfg_pkg::data_width-1:0] data;
    stat_cmd_t                          stat;
  } link_payload_u;

endpackage

// ==== verilog/link_endpoint.sv ====
// host link endpoint, registers requests and forwards loads and stores
// answers stat requests locally with a tagged strobe
`timescale 1ns/1ps

module link_endpoint (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  mem_link_pkg::op_e                   op_i,
  input  logic [mem_cfg_pkg::addr_width-1:0]  addr_i,
  input  mem_link_pkg::link_payload_u         payload_i,
  input  logic                                cache_ack_i,
  input  logic [mem_cfg_pkg::data_width-1:0]  cache_rdata_i,
  input  logic [31:0]                         hit_count_i,
  input  logic [31:0]                         miss_count_i,
  output logic                                ack_o,
  output logic [mem_cfg_pkg::data_width-1:0]  rdata_o,
  output logic                                stat_v_o,
  output logic [15:0]                         stat_tag_o,
  output logic                                cache_req_o,
  output logic                                cache_we_o,
  output logic [mem_cfg_pkg::addr_width-1:0]  cache_addr_o,
  output logic [mem_cfg_pkg::data_width-1:0]  cache_wdata_o
);

  localparam logic [2:0] e_idle   = 3'd0;
  localparam logic [2:0] e_decode = 3'd1;
  localparam logic [2:0] e_cache  = 3'd2;
  localparam logic [2:0] e_drain  = 3'd3;
  localparam logic [2:0] e_resp   = 3'd4;

  logic [2:0]                        state_q;
  mem_link_pkg::op_e                 op_q;
  logic [mem_cfg_pkg::addr_width-1:0] addr_q;
  mem_link_pkg::link_payload_u       payload_q;
  logic                              is_stat;

  assign is_stat = (op_q == mem_link_pkg::op_stat);

  assign cache_we_o = (op_q == mem_link_pkg::op_store);
  assign cache_addr_o = addr_q;
  assign cache_wdata_o = payload_q.data;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= e_idle;
      ack_o <= 1'b0;
      stat_v_o <= 1'b0;
      cache_req_o <= 1'b0;
    end else begin
      stat_v_o <= 1'b0;
      case (state_q)
        e_idle: if (req_i) state_q <= e_decode;
        e_decode: begin
          if (is_stat) begin
            ack_o <= 1'b1;
            stat_v_o <= 1'b1;
            state_q <= e_resp;
          end else begin
            cache_req_o <= 1'b1;
            state_q <= e_cache;
          end
        end
        e_cache: begin
          if (cache_ack_i) begin
            cache_req_o <= 1'b0;
            state_q <= e_drain;
          end
        end
        // cache must finish its handshake first
        e_drain: begin
          if (!cache_ack_i) begin
            ack_o <= 1'b1;
            state_q <= e_resp;
          end
        end
        e_resp: begin
          if (!req_i) begin
            ack_o <= 1'b0;
            state_q <= e_idle;
          end
        end
        default: state_q <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == e_idle && req_i) begin
      op_q <= op_i;
      addr_q <= addr_i;
      payload_q <= payload_i;
    end
    if (state_q == e_decode && is_stat) begin
      rdata_o <= payload_q.stat.sel ? miss_count_i : hit_count_i;
      stat_tag_o <= payload_q.stat.tag;
    end
    if (state_q == e_cache && cache_ack_i) begin
      rdata_o <= cache_rdata_i;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(cache_ack_i) |-> cache_req_o);

endmodule

// ==== verilog/block_cache.sv ====
// blocking direct-mapped write-back cache, one block per set
// whole-block fill and eviction over the DMA port, hit and miss counters
`timescale 1ns/1ps

module block_cache (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  logic [mem_cfg_pkg::addr_width-1:0]         addr_i,
  input  logic [mem_cfg_pkg::data_width-1:0]         wdata_i,
  input  logic                                       dma_ack_i,
  input  logic [mem_cfg_pkg::block_width-1:0]        dma_rblock_i,
  output logic                                       ack_o,
  output logic [mem_cfg_pkg::data_width-1:0]         rdata_o,
  output logic                                       dma_req_o,
  output logic                                       dma_we_o,
  output logic [mem_cfg_pkg::block_addr_width-1:0]   dma_block_addr_o,
  output logic [mem_cfg_pkg::block_width-1:0]        dma_wblock_o,
  output logic [31:0]                                hit_count_o,
  output logic [31:0]                                miss_count_o
);

  localparam logic [2:0] s_idle     = 3'd0;
  localparam logic [2:0] s_lookup   = 3'd1;
  localparam logic [2:0] s_wb       = 3'd2;
  localparam logic [2:0] s_wb_end   = 3'd3;
  localparam logic [2:0] s_fill     = 3'd4;
  localparam logic [2:0] s_fill_end = 3'd5;
  localparam logic [2:0] s_resp     = 3'd6;

  logic [2:0]                              state_q;
  logic [mem_cfg_pkg::tag_width-1:0]       tag_arr [mem_cfg_pkg::num_sets];
  logic [mem_cfg_pkg::block_width-1:0]     data_arr [mem_cfg_pkg::num_sets];
  logic [mem_cfg_pkg::num_sets-1:0]        valid_q;
  logic [mem_cfg_pkg::num_sets-1:0]        dirty_q;

  logic [mem_cfg_pkg::offset_width-1:0]    off;
  logic [mem_cfg_pkg::index_width-1:0]     idx;
  logic [mem_cfg_pkg::tag_width-1:0]       tag;
  logic                                    hit;
  logic                                    victim_dirty;
  logic                                    fill_done;
  logic                                    write_blk;
  logic [mem_cfg_pkg::block_width-1:0]     merged;

  // addr_i is held stable for the whole exchange
  assign off = addr_i[mem_cfg_pkg::offset_width-1:0];
  assign idx = addr_i[mem_cfg_pkg::offset_width +: mem_cfg_pkg::index_width];
  assign tag = addr_i[mem_cfg_pkg::addr_width-1 -: mem_cfg_pkg::tag_width];

  assign hit = valid_q[idx] && (tag_arr[idx] == tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  assign fill_done = (state_q == s_fill) && dma_ack_i;
  assign write_blk = ((state_q == s_lookup) && hit) || fill_done;

  // resident or freshly filled block with the store word merged in
  always_comb begin
    merged = (state_q == s_fill) ? dma_rblock_i : data_arr[idx];
    if (we_i) begin
      merged[off*mem_cfg_pkg::data_width +: mem_cfg_pkg::data_width] = wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= s_idle;
      ack_o <= 1'b0;
      dma_req_o <= 1'b0;
      dma_we_o <= 1'b0;
      valid_q <= '0;
      dirty_q <= '0;
      hit_count_o <= '0;
      miss_count_o <= '0;
    end else begin
      case (state_q)
        s_idle: if (req_i) state_q <= s_lookup;
        s_lookup: begin
          if (hit) begin
            hit_count_o <= hit_count_o + 32'd1;
            if (we_i) dirty_q[idx] <= 1'b1;
            ack_o <= 1'b1;
            state_q <= s_resp;
          end else begin
            // one count per miss, write-back or not
            miss_count_o <= miss_count_o + 32'd1;
            dma_req_o <= 1'b1;
            dma_we_o <= victim_dirty;
            state_q <= victim_dirty ? s_wb : s_fill;
          end
        end
        s_wb: begin
          if (dma_ack_i) begin
            dma_req_o <= 1'b0;
            state_q <= s_wb_end;
          end
        end
        s_wb_end: begin
          if (!dma_ack_i) begin
            dma_req_o <= 1'b1;
            dma_we_o <= 1'b0;
            state_q <= s_fill;
          end
        end
        s_fill: begin
          if (dma_ack_i) begin
            dma_req_o <= 1'b0;
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= we_i;
            state_q <= s_fill_end;
          end
        end
        s_fill_end: begin
          if (!dma_ack_i) begin
            ack_o <= 1'b1;
            state_q <= s_resp;
          end
        end
        s_resp: begin
          if (!req_i) begin
            ack_o <= 1'b0;
            state_q <= s_idle;
          end
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (write_blk) begin
      data_arr[idx] <= merged;
      rdata_o <= merged[off*mem_cfg_pkg::data_width +: mem_cfg_pkg::data_width];
    end
    if (fill_done) tag_arr[idx] <= tag;
    if (state_q == s_lookup && !hit) begin
      if (victim_dirty) begin
        dma_block_addr_o <= {tag_arr[idx], idx};
        dma_wblock_o <= data_arr[idx];
      end else begin
        dma_block_addr_o <= {tag, idx};
      end
    end
    if (state_q == s_wb_end && !dma_ack_i) dma_block_addr_o <= {tag, idx};
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (dma_req_o && !dma_ack_i) |=>
      dma_req_o && $stable(dma_we_o) && $stable(dma_block_addr_o));

  assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown(state_q) && (state_q <= s_resp));

endmodule

// ==== verilog/dma_mem.sv ====
// block-wide backing memory on a four-phase DMA port
// fixed latency from request to acknowledge
`timescale 1ns/1ps

module dma_mem (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  logic [mem_cfg_pkg::block_addr_width-1:0]   block_addr_i,
  input  logic [mem_cfg_pkg::block_width-1:0]        wblock_i,
  output logic                                       ack_o,
  output logic [mem_cfg_pkg::block_width-1:0]        rblock_o
);

  logic [mem_cfg_pkg::block_width-1:0]          mem [mem_cfg_pkg::mem_blocks];
  logic                                         busy_q;
  logic [$clog2(mem_cfg_pkg::mem_latency+1)-1:0] cnt_q;
  logic                                         done;

  // word address xor key
  initial begin
    for (int b = 0; b < mem_cfg_pkg::mem_blocks; b++) begin
      for (int w = 0; w < mem_cfg_pkg::block_words; w++) begin
        mem[b][w*mem_cfg_pkg::data_width +: mem_cfg_pkg::data_width] =
          (b * mem_cfg_pkg::block_words + w) ^ mem_cfg_pkg::mem_init_key;
      end
    end
  end

  assign done = busy_q && (cnt_q == mem_cfg_pkg::mem_latency - 1);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      ack_o <= 1'b0;
    end else if (done) begin
      busy_q <= 1'b0;
      ack_o <= 1'b1;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (ack_o && !req_i) begin
      ack_o <= 1'b0;
    end else if (!ack_o && req_i) begin
      busy_q <= 1'b1;
      cnt_q <= '0;
    end
  end

  always @(posedge clk) begin
    if (done && we_i) mem[block_addr_i] <= wblock_i;
  end

  always_ff @(posedge clk) begin
    if (done) rblock_o <= we_i ? wblock_i : mem[block_addr_i];
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (req_i && !ack_o) |=> req_i);

endmodule

// ==== verilog/spmd_mem_top.sv ====
// memory column top, host link endpoint over cache over backing memory
`timescale 1ns/1ps

module spmd_mem_top (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  mem_link_pkg::op_e                   op_i,
  input  logic [mem_cfg_pkg::addr_width-1:0]  addr_i,
  input  mem_link_pkg::link_payload_u         payload_i,
  output logic                                ack_o,
  output logic [mem_cfg_pkg::data_width-1:0]  rdata_o,
  output logic                                stat_v_o,
  output logic [15:0]                         stat_tag_o
);

  logic                                      cache_req;
  logic                                      cache_we;
  logic [mem_cfg_pkg::addr_width-1:0]        cache_addr;
  logic [mem_cfg_pkg::data_width-1:0]        cache_wdata;
  logic                                      cache_ack;
  logic [mem_cfg_pkg::data_width-1:0]        cache_rdata;
  logic [31:0]                               hit_count;
  logic [31:0]                               miss_count;
  logic                                      dma_req;
  logic                                      dma_we;
  logic [mem_cfg_pkg::block_addr_width-1:0]  dma_block_addr;
  logic [mem_cfg_pkg::block_width-1:0]       dma_wblock;
  logic                                      dma_ack;
  logic [mem_cfg_pkg::block_width-1:0]       dma_rblock;

  link_endpoint link_endpoint_i (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .req_i(req_i),
    .op_i(op_i),
    .addr_i(addr_i),
    .payload_i(payload_i),
    .cache_ack_i(cache_ack),
    .cache_rdata_i(cache_rdata),
    .hit_count_i(hit_count),
    .miss_count_i(miss_count),
    .ack_o(ack_o),
    .rdata_o(rdata_o),
    .stat_v_o(stat_v_o),
    .stat_tag_o(stat_tag_o),
    .cache_req_o(cache_req),
    .cache_we_o(cache_we),
    .cache_addr_o(cache_addr),
    .cache_wdata_o(cache_wdata)
  );

  block_cache block_cache_i (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .req_i(cache_req),
    .we_i(cache_we),
    .addr_i(cache_addr),
    .wdata_i(cache_wdata),
    .dma_ack_i(dma_ack),
    .dma_rblock_i(dma_rblock),
    .ack_o(cache_ack),
    .rdata_o(cache_rdata),
    .dma_req_o(dma_req),
    .dma_we_o(dma_we),
    .dma_block_addr_o(dma_block_addr),
    .dma_wblock_o(dma_wblock),
    .hit_count_o(hit_count),
    .miss_count_o(miss_count)
  );

  dma_mem dma_mem_i (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .req_i(dma_req),
    .we_i(dma_we),
    .block_addr_i(dma_block_addr),
    .wblock_i(dma_wblock),
    .ack_o(dma_ack),
    .rblock_o(dma_rblock)
  );

endmodule

// ==== verif/spmd_mem_tb.sv ====
// testbench for the memory column: stimulus table, reference model
// handshake monitor, checks and cycle-limit timeout
`timescale 1ns/1ps

module spmd_mem_tb;

  localparam int n_entries = 24;
  localparam int cycle_limit = n_entries * 40;
  localparam int n_words = 2 ** mem_cfg_pkg::addr_width;

  logic                                clk = 1'b0;
  logic                                rst_n = 1'b0;
  logic                                req = 1'b0;
  mem_link_pkg::op_e                   op = mem_link_pkg::op_load;
  logic [mem_cfg_pkg::addr_width-1:0]  addr = '0;
  mem_link_pkg::link_payload_u         payload = '0;
  logic                                ack_o;
  logic [mem_cfg_pkg::data_width-1:0]  rdata_o;
  logic                                stat_v_o;
  logic [15:0]                         stat_tag_o;

  mem_link_pkg::op_e                   op_tab [n_entries];
  logic [mem_cfg_pkg::addr_width-1:0]  addr_tab [n_entries];
  mem_link_pkg::link_payload_u         pay_tab [n_entries];
  logic [31:0]                         exp_tab [n_entries];
  int                                  n_used = 0;

  // reference model state
  logic [31:0]                         ref_mem [n_words];
  logic [mem_cfg_pkg::tag_width-1:0]   tag_mirror [mem_cfg_pkg::num_sets];
  logic [mem_cfg_pkg::num_sets-1:0]    valid_mirror;

  integer seed = 32'hb928;
  int     errors = 0;
  int     cycles = 0;
  int     stat_pulses = 0;
  int     stat_reqs = 0;
  logic   ack_prev = 1'b0;
  logic   req_prev = 1'b0;

  spmd_mem_top spmd_mem_top_i (
    .clk(clk),
    .rst_n_i(rst_n),
    .req_i(req),
    .op_i(op),
    .addr_i(addr),
    .payload_i(payload),
    .ack_o(ack_o),
    .rdata_o(rdata_o),
    .stat_v_o(stat_v_o),
    .stat_tag_o(stat_tag_o)
  );

  always #5 clk = ~clk;

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_access(input mem_link_pkg::op_e o, input int a, input logic [31:0] d);
    op_tab[n_used] = o;
    addr_tab[n_used] = a[mem_cfg_pkg::addr_width-1:0];
    pay_tab[n_used] = '0;
    pay_tab[n_used].data = d;
    n_used++;
  endtask

  task automatic push_stat(input logic [15:0] tag, input logic sel);
    op_tab[n_used] = mem_link_pkg::op_stat;
    addr_tab[n_used] = '0;
    pay_tab[n_used] = '0;
    pay_tab[n_used].stat.tag = tag;
    pay_tab[n_used].stat.sel = sel;
    n_used++;
  endtask

  // direct-mapped mirror, memory content as the host sees it
  task automatic predict_results();
    int hits;
    int misses;
    int idx;
    logic [mem_cfg_pkg::tag_width-1:0] tg;
    hits = 0;
    misses = 0;
    valid_mirror = '0;
    for (int a = 0; a < n_words; a++) ref_mem[a] = a ^ mem_cfg_pkg::mem_init_key;
    for (int i = 0; i < n_used; i++) begin
      idx = addr_tab[i][mem_cfg_pkg::offset_width +: mem_cfg_pkg::index_width];
      tg = addr_tab[i][mem_cfg_pkg::addr_width-1 -: mem_cfg_pkg::tag_width];
      if (op_tab[i] == mem_link_pkg::op_stat) begin
        exp_tab[i] = pay_tab[i].stat.sel ? misses : hits;
        stat_reqs++;
      end else begin
        if (valid_mirror[idx] && tag_mirror[idx] == tg) begin
          hits++;
        end else begin
          misses++;
          valid_mirror[idx] = 1'b1;
          tag_mirror[idx] = tg;
        end
        if (op_tab[i] == mem_link_pkg::op_store) ref_mem[addr_tab[i]] = pay_tab[i].data;
        exp_tab[i] = ref_mem[addr_tab[i]];
      end
    end
  endtask

  task automatic run_entry(input int i);
    int gap;
    gap = {$random(seed)} % 4;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    req <= 1'b1;
    op <= op_tab[i];
    addr <= addr_tab[i];
    payload <= pay_tab[i];
    @(negedge clk);
    while (!ack_o) @(negedge clk);
    if (op_tab[i] != mem_link_pkg::op_store) compare_val("rdata_o", rdata_o, exp_tab[i]);
    if (op_tab[i] == mem_link_pkg::op_stat) begin
      compare_val("stat_v_o", stat_v_o, 32'd1);
      compare_val("stat_tag_o", stat_tag_o, pay_tab[i].stat.tag);
    end else begin
      compare_val("stat_v_o", stat_v_o, 32'd0);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack_o) @(negedge clk);
  endtask

  // four-phase order at the host link
  always @(negedge clk) begin
    if (rst_n) begin
      if (ack_o && !ack_prev && !req) begin
        errors++;
        $display("handshake error at %0t: ack_o rose while req_i was low", $time);
      end
      if (!ack_o && ack_prev && req_prev) begin
        errors++;
        $display("handshake error at %0t: ack_o fell before req_i fell", $time);
      end
      if (stat_v_o) stat_pulses++;
    end
    ack_prev = ack_o;
    req_prev = req;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int ra;
    int rb;
    int rc;
    ra = {$random(seed)} % n_words;
    rb = {$random(seed)} % n_words;
    rc = {$random(seed)} % n_words;
    add_access(mem_link_pkg::op_load, 'h010, 0);
    add_access(mem_link_pkg::op_load, 'h011, 0);
    add_access(mem_link_pkg::op_store, 'h012, 32'hcafe_0001);
    add_access(mem_link_pkg::op_load, 'h012, 0);
    push_stat(16'h0101, 1'b0);
    push_stat(16'h0102, 1'b1);
    // same set as 0x010, dirty victim goes back to memory
    add_access(mem_link_pkg::op_load, 'h030, 0);
    add_access(mem_link_pkg::op_load, 'h012, 0);
    add_access(mem_link_pkg::op_store, 'h1f4, 32'h1234_5678);
    add_access(mem_link_pkg::op_store, 'h0f5, 32'h0bad_f00d);
    add_access(mem_link_pkg::op_load, 'h1f4, 0);
    add_access(mem_link_pkg::op_load, 'h0f5, 0);
    push_stat(16'h0203, 1'b1);
    add_access(mem_link_pkg::op_load, ra, 0);
    add_access(mem_link_pkg::op_load, rb, 0);
    add_access(mem_link_pkg::op_store, rc, 32'h7e57_a11c);
    add_access(mem_link_pkg::op_load, rc, 0);
    add_access(mem_link_pkg::op_store, 'h3fc, 32'hdead_beef);
    add_access(mem_link_pkg::op_load, 'h3fc, 0);
    add_access(mem_link_pkg::op_load, 'h1fc, 0);
    add_access(mem_link_pkg::op_load, 'h3fc, 0);
    push_stat(16'h0304, 1'b0);
    push_stat(16'h0305, 1'b1);
    push_stat(16'hbeef, 1'b0);
    predict_results();

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_val("ack_o", ack_o, 32'd0);
    compare_val("stat_v_o", stat_v_o, 32'd0);

    for (int i = 0; i < n_used; i++) run_entry(i);
    repeat (2) @(negedge clk);
    compare_val("stat pulse count", stat_pulses, stat_reqs);

    $display("done: %0d entries, %0d errors", n_used, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== spmd_mem.f ====
verilog/mem_cfg_pkg.sv
verilog/mem_link_pkg.sv
verilog/link_endpoint.sv
verilog/block_cache.sv
verilog/dma_mem.sv
verilog/spmd_mem_top.sv
verif/spmd_mem_tb.sv

// ==== Bender.yml ====
package:
  name: spmd_mem

sources:
  # packages first, the link package uses the config package
  - verilog/mem_cfg_pkg.sv
  - verilog/mem_link_pkg.sv
  # design
  - verilog/link_endpoint.sv
  - verilog/block_cache.sv
  - verilog/dma_mem.sv
  - verilog/spmd_mem_top.sv
  # testbench
  - target: test
    files:
      - verif/spmd_mem_tb.sv
